/* design/ing_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// MPLS ingress shared definitions
////////////////////////////////////////////////////////////////////////////

package ing_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Converged bus

  // Bytes per converged word and its bit width
  localparam int OUT_BYTES = 8;
  localparam int OUT_W = OUT_BYTES * 8;
  // Lane counter wide enough to address any byte of a word
  localparam int LANE_W = $clog2(OUT_BYTES);

  ////////////////////////////////////////////////////////////////////////////
  // Physical ports

  localparam int NUM_PORTS = 3;
  // Port index travels on tuser
  localparam int PORT_IDX_W = 2;
  // Bytes per beat on ports 0, 1 and 2
  localparam int PORT_BYTES [NUM_PORTS] = '{1, 2, 4};

  ////////////////////////////////////////////////////////////////////////////
  // Packet buffers

  localparam int BUF_WORDS = 16;
  localparam int BUF_ADDR_W = $clog2(BUF_WORDS);
  // Extra wrap bit tells full from empty
  localparam int BUF_PTR_W = BUF_ADDR_W + 1;

  // Arbiter states
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_PKT  = 1'b1
  } arb_state_t;

endpackage

/* design/ing_width_pack.sv */
////////////////////////////////////////////////////////////////////////////
// Narrow port to converged word packer
////////////////////////////////////////////////////////////////////////////

module ing_width_pack #(
  parameter int IN_BYTES = 1
) (
  input  logic                          clk,
  input  logic                          rst,
  // Physical port, every valid beat is full and is always taken
  input  logic                          in_tvalid,
  input  logic [IN_BYTES*8-1:0]         in_tdata,
  input  logic                          in_tlast,
  // Packed words toward the packet buffer
  output logic                          pk_valid,
  output logic [ing_pkg::OUT_W-1:0]     pk_data,
  output logic [ing_pkg::OUT_BYTES-1:0] pk_keep,
  output logic                          pk_last
);

  // Byte lane where the next beat lands
  logic [ing_pkg::LANE_W-1:0]    lane;
  // Partially filled word
  logic [ing_pkg::OUT_W-1:0]     word_q;
  // Word with the current beat merged in
  logic [ing_pkg::OUT_W-1:0]     word_next;
  logic [ing_pkg::OUT_BYTES-1:0] keep_next;
  logic                          word_full;
  logic                          emit;

  ////////////////////////////////////////////////////////////////////////////
  // Beat placement

  always_comb begin
    word_next = word_q;
    word_next[lane*8 +: IN_BYTES*8] = in_tdata;
    // Keep covers every lane filled so far, low lanes first
    for (int b = 0; b < ing_pkg::OUT_BYTES; b++) begin
      keep_next[b] = (b < int'(lane) + IN_BYTES);
      // Unfilled lanes of a short last word go out as zero
      if (!keep_next[b]) begin
        word_next[b*8 +: 8] = 8'h00;
      end
    end
    word_full = (int'(lane) + IN_BYTES) == ing_pkg::OUT_BYTES;
  end

  // Emit on a full word or at end of packet
  assign emit = in_tvalid && (word_full || in_tlast);

  ////////////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (rst) begin
      lane     <= '0;
      pk_valid <= 1'b0;
    end else begin
      pk_valid <= emit;
      if (emit) begin
        // Next packet or next word starts at lane 0
        lane <= '0;
      end else if (in_tvalid) begin
        lane <= lane + ing_pkg::LANE_W'(IN_BYTES);
      end
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if (in_tvalid) begin
      word_q <= word_next;
    end
    if (emit) begin
      pk_data <= word_next;
      pk_keep <= keep_next;
      pk_last <= in_tlast;
    end
  end

endmodule

/* design/ing_pkt_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// Per-port packet buffer
////////////////////////////////////////////////////////////////////////////

module ing_pkt_buffer (
  input  logic                          clk,
  input  logic                          rst,
  // Packed words, no back-pressure on this side
  input  logic                          pk_valid,
  input  logic [ing_pkg::OUT_W-1:0]     pk_data,
  input  logic [ing_pkg::OUT_BYTES-1:0] pk_keep,
  input  logic                          pk_last,
  // Committed packets toward the arbiter
  output logic                          buf_tvalid,
  output logic [ing_pkg::OUT_W-1:0]     buf_tdata,
  output logic [ing_pkg::OUT_BYTES-1:0] buf_tkeep,
  output logic                          buf_tlast,
  input  logic                          buf_tready,
  // One cycle pulse when a packet is dropped
  output logic                          overflow
);

  // Word storage
  logic [ing_pkg::OUT_W-1:0]     mem_data [ing_pkg::BUF_WORDS];
  logic [ing_pkg::OUT_BYTES-1:0] mem_keep [ing_pkg::BUF_WORDS];
  logic                          mem_last [ing_pkg::BUF_WORDS];

  // Write, commit and read pointers with wrap bit
  logic [ing_pkg::BUF_PTR_W-1:0] wr_ptr;
  logic [ing_pkg::BUF_PTR_W-1:0] cm_ptr;
  logic [ing_pkg::BUF_PTR_W-1:0] rd_ptr;
  // Words held, committed or not
  logic [ing_pkg::BUF_PTR_W-1:0] used;
  logic                          full;
  // Discarding the tail of a dropped packet
  logic                          drop_q;
  logic                          wr_en;

  assign used  = wr_ptr - rd_ptr;
  assign full  = used == ing_pkg::BUF_WORDS;
  assign wr_en = pk_valid && !drop_q && !full;

  ////////////////////////////////////////////////////////////////////////////
  // Write side

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      cm_ptr   <= '0;
      drop_q   <= 1'b0;
      overflow <= 1'b0;
    end else begin
      overflow <= 1'b0;
      if (pk_valid && drop_q) begin
        // Skip until the dropped packet ends
        if (pk_last) begin
          drop_q <= 1'b0;
        end
      end else if (pk_valid && full) begin
        // No room, roll back the whole uncommitted packet
        wr_ptr   <= cm_ptr;
        overflow <= 1'b1;
        drop_q   <= !pk_last;
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
        // Last word makes the packet visible to the reader
        if (pk_last) begin
          cm_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_data[wr_ptr[ing_pkg::BUF_ADDR_W-1:0]] <= pk_data;
      mem_keep[wr_ptr[ing_pkg::BUF_ADDR_W-1:0]] <= pk_keep;
      mem_last[wr_ptr[ing_pkg::BUF_ADDR_W-1:0]] <= pk_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read side

  // Only committed words are offered
  assign buf_tvalid = rd_ptr != cm_ptr;
  assign buf_tdata  = mem_data[rd_ptr[ing_pkg::BUF_ADDR_W-1:0]];
  assign buf_tkeep  = mem_keep[rd_ptr[ing_pkg::BUF_ADDR_W-1:0]];
  assign buf_tlast  = mem_last[rd_ptr[ing_pkg::BUF_ADDR_W-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (buf_tvalid && buf_tready) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

/* design/ing_rr_mux.sv */
////////////////////////////////////////////////////////////////////////////
// Round-robin packet arbiter
////////////////////////////////////////////////////////////////////////////

module ing_rr_mux (
  input  logic                                            clk,
  input  logic                                            rst,
  // Port buffers, word p sits at slice p
  input  logic [ing_pkg::NUM_PORTS-1:0]                   buf_tvalid,
  input  logic [ing_pkg::NUM_PORTS*ing_pkg::OUT_W-1:0]     buf_tdata,
  input  logic [ing_pkg::NUM_PORTS*ing_pkg::OUT_BYTES-1:0] buf_tkeep,
  input  logic [ing_pkg::NUM_PORTS-1:0]                   buf_tlast,
  output logic [ing_pkg::NUM_PORTS-1:0]                   buf_tready,
  // Converged bus
  output logic                                            out_tvalid,
  output logic [ing_pkg::OUT_W-1:0]                       out_tdata,
  output logic [ing_pkg::OUT_BYTES-1:0]                   out_tkeep,
  output logic                                            out_tlast,
  output logic [ing_pkg::PORT_IDX_W-1:0]                  out_tuser,
  input  logic                                            out_tready
);

  ing_pkg::arb_state_t             state;
  // Port that owns the bus for the current packet
  logic [ing_pkg::PORT_IDX_W-1:0] grant;
  // Highest priority port for the next packet
  logic [ing_pkg::PORT_IDX_W-1:0] ptr;
  logic [ing_pkg::PORT_IDX_W-1:0] pick;
  logic                           last_acc;

  ////////////////////////////////////////////////////////////////////////////
  // Pick the first valid port at or after the pointer

  always_comb begin
    int idx;
    pick = ptr;
    // Walk backwards so the nearest port wins
    for (int i = ing_pkg::NUM_PORTS - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % ing_pkg::NUM_PORTS;
      if (buf_tvalid[idx]) begin
        pick = ing_pkg::PORT_IDX_W'(idx);
      end
    end
  end

  // Forward the granted buffer while a packet is open
  always_comb begin
    buf_tready = '0;
    out_tvalid = 1'b0;
    out_tdata  = buf_tdata[grant*ing_pkg::OUT_W +: ing_pkg::OUT_W];
    out_tkeep  = buf_tkeep[grant*ing_pkg::OUT_BYTES +: ing_pkg::OUT_BYTES];
    out_tlast  = buf_tlast[grant];
    out_tuser  = grant;
    if (state == ing_pkg::ARB_PKT) begin
      out_tvalid        = buf_tvalid[grant];
      buf_tready[grant] = out_tready;
    end
  end

  assign last_acc = out_tvalid && out_tready && out_tlast;

  ////////////////////////////////////////////////////////////////////////////
  // Grant FSM

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ing_pkg::ARB_IDLE;
      grant <= '0;
      ptr   <= '0;
    end else begin
      case (state)
        ing_pkg::ARB_IDLE: begin
          // Lock the grant before any word is offered
          if (|buf_tvalid) begin
            grant <= pick;
            state <= ing_pkg::ARB_PKT;
          end
        end
        default: begin
          if (last_acc) begin
            state <= ing_pkg::ARB_IDLE;
            // Rotate priority past the port just served
            if (grant == ing_pkg::PORT_IDX_W'(ing_pkg::NUM_PORTS - 1)) begin
              ptr <= '0;
            end else begin
              ptr <= grant + 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

/* design/mpls_ingress.sv */
////////////////////////////////////////////////////////////////////////////
// MPLS ingress front end
////////////////////////////////////////////////////////////////////////////

module mpls_ingress (
  input  logic                                  clk,
  input  logic                                  rst,
  // Physical port 0
  input  logic                                  p0_tvalid,
  input  logic [ing_pkg::PORT_BYTES[0]*8-1:0]   p0_tdata,
  input  logic                                  p0_tlast,
  // Physical port 1
  input  logic                                  p1_tvalid,
  input  logic [ing_pkg::PORT_BYTES[1]*8-1:0]   p1_tdata,
  input  logic                                  p1_tlast,
  // Physical port 2
  input  logic                                  p2_tvalid,
  input  logic [ing_pkg::PORT_BYTES[2]*8-1:0]   p2_tdata,
  input  logic                                  p2_tlast,
  // Converged bus
  output logic                                  out_tvalid,
  output logic [ing_pkg::OUT_W-1:0]             out_tdata,
  output logic [ing_pkg::OUT_BYTES-1:0]         out_tkeep,
  output logic                                  out_tlast,
  output logic [ing_pkg::PORT_IDX_W-1:0]        out_tuser,
  input  logic                                  out_tready,
  // Per-port drop pulses
  output logic [ing_pkg::NUM_PORTS-1:0]         overflow
);

  // Packer to buffer
  logic                          pk_valid [ing_pkg::NUM_PORTS];
  logic [ing_pkg::OUT_W-1:0]     pk_data  [ing_pkg::NUM_PORTS];
  logic [ing_pkg::OUT_BYTES-1:0] pk_keep  [ing_pkg::NUM_PORTS];
  logic                          pk_last  [ing_pkg::NUM_PORTS];

  // Buffer to arbiter, packed per port
  logic [ing_pkg::NUM_PORTS-1:0]                   buf_tvalid;
  logic [ing_pkg::NUM_PORTS*ing_pkg::OUT_W-1:0]     buf_tdata;
  logic [ing_pkg::NUM_PORTS*ing_pkg::OUT_BYTES-1:0] buf_tkeep;
  logic [ing_pkg::NUM_PORTS-1:0]                   buf_tlast;
  logic [ing_pkg::NUM_PORTS-1:0]                   buf_tready;

  ////////////////////////////////////////////////////////////////////////////
  // Width packing, one per physical port

  ing_width_pack #(.IN_BYTES(ing_pkg::PORT_BYTES[0])) u_pack0 (
    .clk(clk), .rst(rst),
    .in_tvalid(p0_tvalid), .in_tdata(p0_tdata), .in_tlast(p0_tlast),
    .pk_valid(pk_valid[0]), .pk_data(pk_data[0]),
    .pk_keep(pk_keep[0]), .pk_last(pk_last[0])
  );

  ing_width_pack #(.IN_BYTES(ing_pkg::PORT_BYTES[1])) u_pack1 (
    .clk(clk), .rst(rst),
    .in_tvalid(p1_tvalid), .in_tdata(p1_tdata), .in_tlast(p1_tlast),
    .pk_valid(pk_valid[1]), .pk_data(pk_data[1]),
    .pk_keep(pk_keep[1]), .pk_last(pk_last[1])
  );

  ing_width_pack #(.IN_BYTES(ing_pkg::PORT_BYTES[2])) u_pack2 (
    .clk(clk), .rst(rst),
    .in_tvalid(p2_tvalid), .in_tdata(p2_tdata), .in_tlast(p2_tlast),
    .pk_valid(pk_valid[2]), .pk_data(pk_data[2]),
    .pk_keep(pk_keep[2]), .pk_last(pk_last[2])
  );

  // Packet buffers
  for (genvar p = 0; p < ing_pkg::NUM_PORTS; p++) begin : g_buf
    ing_pkt_buffer u_buf (
      .clk(clk), .rst(rst),
      .pk_valid(pk_valid[p]), .pk_data(pk_data[p]),
      .pk_keep(pk_keep[p]), .pk_last(pk_last[p]),
      .buf_tvalid(buf_tvalid[p]),
      .buf_tdata(buf_tdata[p*ing_pkg::OUT_W +: ing_pkg::OUT_W]),
      .buf_tkeep(buf_tkeep[p*ing_pkg::OUT_BYTES +: ing_pkg::OUT_BYTES]),
      .buf_tlast(buf_tlast[p]),
      .buf_tready(buf_tready[p]),
      .overflow(overflow[p])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Merge onto the converged bus

  ing_rr_mux u_mux (
    .clk(clk), .rst(rst),
    .buf_tvalid(buf_tvalid), .buf_tdata(buf_tdata),
    .buf_tkeep(buf_tkeep), .buf_tlast(buf_tlast), .buf_tready(buf_tready),
    .out_tvalid(out_tvalid), .out_tdata(out_tdata), .out_tkeep(out_tkeep),
    .out_tlast(out_tlast), .out_tuser(out_tuser), .out_tready(out_tready)
  );

endmodule

/* dv/mpls_ingress_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Converged bus assertions
////////////////////////////////////////////////////////////////////////////

module mpls_ingress_checker (
  input logic                           clk,
  input logic                           rst,
  input logic                           out_tvalid,
  input logic [ing_pkg::OUT_W-1:0]      out_tdata,
  input logic [ing_pkg::OUT_BYTES-1:0]  out_tkeep,
  input logic                           out_tlast,
  input logic [ing_pkg::PORT_IDX_W-1:0] out_tuser,
  input logic                           out_tready
);

  // Stalled word holds until taken
  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
      $stable(out_tkeep) && $stable(out_tlast) && $stable(out_tuser))
    else $error("converged bus word changed while stalled");

  // Port tag fixed from the first word through tlast
  a_tuser: assert property (@(posedge clk) disable iff (rst)
    out_tvalid && out_tready && !out_tlast |=> $stable(out_tuser))
    else $error("tuser changed inside a packet");

  // Bus idle once reset has been seen
  a_reset: assert property (@(posedge clk) rst && $past(rst) |-> !out_tvalid)
    else $error("out_tvalid high during reset");

endmodule

bind mpls_ingress mpls_ingress_checker u_checker (
  .clk(clk), .rst(rst), .out_tvalid(out_tvalid), .out_tdata(out_tdata),
  .out_tkeep(out_tkeep), .out_tlast(out_tlast), .out_tuser(out_tuser),
  .out_tready(out_tready)
);

/* dv/mpls_ingress_tb.sv */
////////////////////////////////////////////////////////////////////////////
// MPLS ingress testbench
////////////////////////////////////////////////////////////////////////////

module mpls_ingress_tb;

  // Packet length range and idle gap between packets
  localparam int MAX_BEATS = 8;
  localparam int MAX_GAP = 4;
  // Packets per port in the random phase
  localparam int RAND_PKTS = 40;
  // Rotation rounds, overflow fill and random traffic, each packet bounded by
  // its beats plus gap, with a wide margin for stalls and drain
  localparam int TOTAL_PKTS = 6 + ing_pkg::NUM_PORTS * (ing_pkg::BUF_WORDS + 2)
                              + ing_pkg::NUM_PORTS * RAND_PKTS;
  localparam int WATCHDOG_CYCLES = TOTAL_PKTS * (MAX_BEATS + MAX_GAP + 2) * 4 + 1000;

  logic                                clk;
  logic                                rst;
  logic                                p0_tvalid;
  logic [ing_pkg::PORT_BYTES[0]*8-1:0] p0_tdata;
  logic                                p0_tlast;
  logic                                p1_tvalid;
  logic [ing_pkg::PORT_BYTES[1]*8-1:0] p1_tdata;
  logic                                p1_tlast;
  logic                                p2_tvalid;
  logic [ing_pkg::PORT_BYTES[2]*8-1:0] p2_tdata;
  logic                                p2_tlast;
  logic                                out_tvalid;
  logic [ing_pkg::OUT_W-1:0]           out_tdata;
  logic [ing_pkg::OUT_BYTES-1:0]       out_tkeep;
  logic                                out_tlast;
  logic [ing_pkg::PORT_IDX_W-1:0]      out_tuser;
  logic                                out_tready;
  logic [ing_pkg::NUM_PORTS-1:0]       overflow;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state

  integer      seed;
  // Expected words per port as {last, keep, data}
  logic [72:0] exp_q [ing_pkg::NUM_PORTS][$];
  // Words accepted into each buffer and not yet seen on the bus
  int          occ [ing_pkg::NUM_PORTS];
  int          drops [ing_pkg::NUM_PORTS];
  int          ovf_seen [ing_pkg::NUM_PORTS];
  // Port of each packet in the order it started on the bus
  int          got_order [$];
  // Bus stalled on purpose, so occupancy is exact and drops can be predicted
  logic        hold_low;
  logic        rand_done;
  logic        in_pkt;
  int          cur_port;

  mpls_ingress DUT (
    .clk(clk), .rst(rst),
    .p0_tvalid(p0_tvalid), .p0_tdata(p0_tdata), .p0_tlast(p0_tlast),
    .p1_tvalid(p1_tvalid), .p1_tdata(p1_tdata), .p1_tlast(p1_tlast),
    .p2_tvalid(p2_tvalid), .p2_tdata(p2_tdata), .p2_tlast(p2_tlast),
    .out_tvalid(out_tvalid), .out_tdata(out_tdata), .out_tkeep(out_tkeep),
    .out_tlast(out_tlast), .out_tuser(out_tuser), .out_tready(out_tready),
    .overflow(overflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "check failed");
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Words a packet fills once its bytes are packed eight to a word
  function automatic int words_for(input int p, input int nbeats);
    return (nbeats * ing_pkg::PORT_BYTES[p] + ing_pkg::OUT_BYTES - 1) / ing_pkg::OUT_BYTES;
  endfunction

  function automatic logic [63:0] masked(input logic [63:0] data, input logic [7:0] keep);
    logic [63:0] m;
    m = '0;
    for (int b = 0; b < 8; b++) begin
      if (keep[b]) begin
        m[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return m;
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  task automatic drive_beat(input int p, input logic valid, input logic [31:0] data,
                            input logic last);
    case (p)
      0: begin
        p0_tvalid <= valid;
        p0_tdata  <= data[7:0];
        p0_tlast  <= last;
      end
      1: begin
        p1_tvalid <= valid;
        p1_tdata  <= data[15:0];
        p1_tlast  <= last;
      end
      default: begin
        p2_tvalid <= valid;
        p2_tdata  <= data;
        p2_tlast  <= last;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Packet stimulus and expected words

  task automatic send_pkt(input int p, input int nbeats);
    int          pb;
    int          nbytes;
    int          nwords;
    int          lane;
    logic [31:0] beats [MAX_BEATS];
    logic [63:0] word;
    logic [7:0]  keep;
    pb     = ing_pkg::PORT_BYTES[p];
    nbytes = nbeats * pb;
    nwords = words_for(p, nbeats);
    for (int i = 0; i < nbeats; i++) begin
      beats[i] = $random(seed);
    end
    if (hold_low && nwords > ing_pkg::BUF_WORDS - occ[p]) begin
      // Will not fit while stalled, whole packet goes
      drops[p]++;
    end else begin
      occ[p] += nwords;
      word = '0;
      keep = '0;
      // Low byte of a beat comes first on the wire
      for (int b = 0; b < nbytes; b++) begin
        lane = b % ing_pkg::OUT_BYTES;
        word[lane*8 +: 8] = beats[b / pb][(b % pb)*8 +: 8];
        keep[lane] = 1'b1;
        if (lane == ing_pkg::OUT_BYTES - 1 || b == nbytes - 1) begin
          exp_q[p].push_back({logic'(b == nbytes - 1), keep, word});
          word = '0;
          keep = '0;
        end
      end
    end
    for (int i = 0; i < nbeats; i++) begin
      @(posedge clk);
      drive_beat(p, 1'b1, beats[i], logic'(i == nbeats - 1));
    end
    @(posedge clk);
    drive_beat(p, 1'b0, 32'h0, 1'b0);
  endtask

  // Random packets on one port, held back until the buffer has room
  task automatic port_traffic(input int p, input int npkts);
    int nbeats;
    for (int k = 0; k < npkts; k++) begin
      nbeats = 1 + rand_below(MAX_BEATS);
      while (occ[p] + words_for(p, nbeats) > ing_pkg::BUF_WORDS) begin
        @(posedge clk);
      end
      send_pkt(p, nbeats);
      repeat (rand_below(MAX_GAP)) @(posedge clk);
    end
  endtask

  task automatic release_and_drain();
    @(posedge clk);
    out_tready <= 1'b1;
    while (pending() != 0) begin
      @(posedge clk);
    end
  endtask

  task automatic check_order(input int first, input int second, input int third);
    check_eq(64'(got_order.size()), 64'd3, "packets in rotation round");
    check_eq(64'(got_order[0]), 64'(first), "first granted port");
    check_eq(64'(got_order[1]), 64'(second), "second granted port");
    check_eq(64'(got_order[2]), 64'(third), "third granted port");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Converged bus monitor

  initial begin : monitor
    logic [72:0] exp_word;
    int          port;
    in_pkt   = 1'b0;
    cur_port = 0;
    for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
      ovf_seen[p] = 0;
    end
    forever begin
      @(posedge clk);
      if (!rst) begin
        for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
          if (overflow[p]) begin
            ovf_seen[p]++;
          end
        end
        if (out_tvalid && out_tready) begin
          port = int'(out_tuser);
          if (!in_pkt) begin
            got_order.push_back(port);
            cur_port = port;
          end
          check_eq(64'(port < ing_pkg::NUM_PORTS), 64'd1, "tuser outside the port range");
          check_eq(64'(port == cur_port), 64'd1, "word from another port inside a packet");
          check_eq(64'(exp_q[port].size() > 0), 64'd1, "word with no packet expected");
          exp_word = exp_q[port].pop_front();
          check_eq(64'(out_tkeep), 64'(exp_word[71:64]), "tkeep");
          check_eq(masked(out_tdata, out_tkeep), exp_word[63:0], "tdata");
          check_eq(64'(out_tlast), 64'(exp_word[72]), "tlast");
          occ[port]--;
          in_pkt = !out_tlast;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    seed       = 32'h7d994b42;
    rst        = 1'b1;
    p0_tvalid  = 1'b0;
    p0_tdata   = '0;
    p0_tlast   = 1'b0;
    p1_tvalid  = 1'b0;
    p1_tdata   = '0;
    p1_tlast   = 1'b0;
    p2_tvalid  = 1'b0;
    p2_tdata   = '0;
    p2_tlast   = 1'b0;
    out_tready = 1'b0;
    hold_low   = 1'b1;
    rand_done  = 1'b0;
    for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
      occ[p]   = 0;
      drops[p] = 0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Rotation from reset, one packet per port loaded while stalled
    send_pkt(0, 3);
    send_pkt(1, 5);
    send_pkt(2, 7);
    release_and_drain();
    check_order(0, 1, 2);

    // Port 1 locks the grant first, priority then moves on to port 2
    got_order.delete();
    @(posedge clk);
    out_tready <= 1'b0;
    send_pkt(1, 4);
    send_pkt(2, 2);
    send_pkt(0, 8);
    release_and_drain();
    check_order(1, 2, 0);

    // Fill each buffer while stalled until two packets are dropped
    @(posedge clk);
    out_tready <= 1'b0;
    for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
      while (drops[p] < 2) begin
        send_pkt(p, 1 + rand_below(MAX_BEATS));
        @(posedge clk);
      end
    end
    release_and_drain();
    for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
      check_eq(64'(ovf_seen[p]), 64'(drops[p]), "overflow pulses after fill");
    end

    // Mixed traffic on all ports with a random bus stall
    hold_low = 1'b0;
    fork
      begin
        fork
          port_traffic(0, RAND_PKTS);
          port_traffic(1, RAND_PKTS);
          port_traffic(2, RAND_PKTS);
        join
        rand_done = 1'b1;
      end
      while (!rand_done) begin
        @(posedge clk);
        out_tready <= rand_below(4) != 0;
      end
    join
    release_and_drain();
    for (int p = 0; p < ing_pkg::NUM_PORTS; p++) begin
      check_eq(64'(ovf_seen[p]), 64'(drops[p]), "overflow pulses after random traffic");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

/* all.f */
design/ing_pkg.sv
design/ing_width_pack.sv
design/ing_pkt_buffer.sv
design/ing_rr_mux.sv
design/mpls_ingress.sv
dv/mpls_ingress_checker.sv
dv/mpls_ingress_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the MPLS ingress testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module mpls_ingress_tb \
  -o mpls_ingress_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/mpls_ingress_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
